//--- include/list_table_defines.svh
// Table geometry macros; LT_SLOTS must be a power of two and fit within LT_LEVEL_W bits
`ifndef LIST_TABLE_DEFINES_SVH
`define LIST_TABLE_DEFINES_SVH

// Entries held by one list
`define LT_SLOTS 4

// Number of lists, addressed by the list id
`define LT_LISTS 64
`define LT_ID_W 6

// Entry payload widths
`define LT_KEY_W 64
`define LT_SIZE_W 32

// Query level and reported list size
`define LT_LEVEL_W 8

`endif

//--- hdl/list_table_pkg.sv
// Shared types; entry and list layouts follow the widths in the defines header
`include "list_table_defines.svh"

package list_table_pkg;

  // Update opcodes, encoding matches the upt_op input
  typedef enum logic [1:0] {
    OP_CLEAR   = 2'b00,
    OP_ADD     = 2'b01,
    OP_DELETE  = 2'b10,
    OP_REPLACE = 2'b11
  } op_e;

  // One slot of a list
  typedef struct packed {
    logic                  valid;
    logic [`LT_KEY_W-1:0]  key;
    logic [`LT_SIZE_W-1:0] size;
  } entry_t;

  // Whole list, one memory word
  typedef entry_t [`LT_SLOTS-1:0] list_state_t;

  // Update command as it travels down the pipeline
  typedef struct packed {
    logic [`LT_ID_W-1:0]   id;
    op_e                   op;
    logic [`LT_KEY_W-1:0]  key;
    logic [`LT_SIZE_W-1:0] size;
  } upt_cmd_t;

endpackage

//--- hdl/table_port_if.sv
// One read port plus one write port of a list-state memory; read data lags rd_en by one edge
`timescale 1ns/1ps
`include "list_table_defines.svh"

interface table_port_if;
  import list_table_pkg::*;

  logic                rd_en;
  logic [`LT_ID_W-1:0] rd_addr;
  list_state_t         rd_data;
  logic                wr_en;
  logic [`LT_ID_W-1:0] wr_addr;
  list_state_t         wr_data;

  // Pipeline side drives requests and write data
  modport pipe (output rd_en, rd_addr, wr_en, wr_addr, wr_data, input rd_data);

  // Memory side returns the read word
  modport mem (input rd_en, rd_addr, wr_en, wr_addr, wr_data, output rd_data);

endinterface

//--- hdl/list_state_ram.sv
// List-state memory, zeroed at start only; reads of an address written on the same edge see old data
`timescale 1ns/1ps
`include "list_table_defines.svh"

module list_state_ram (
  input logic        clk,
  table_port_if.mem  port
);
  import list_table_pkg::*;

  list_state_t mem [`LT_LISTS];
  list_state_t rd_data_q;

  // Every list starts out empty
  initial begin
    for (int i = 0; i < `LT_LISTS; i++) begin
      mem[i] = '0;
    end
  end

  // Write port
  always_ff @(posedge clk) begin
    if (port.wr_en) begin
      mem[port.wr_addr] <= port.wr_data;
    end
  end

  // Registered read, holds its value while rd_en is low
  always_ff @(posedge clk) begin
    if (port.rd_en) begin
      rd_data_q <= mem[port.rd_addr];
    end
  end

  assign port.rd_data = rd_data_q;

endmodule

//--- hdl/update_pipe.sv
// Four-stage update pipeline, one command per cycle with no back-pressure; write lands four edges after issue
`timescale 1ns/1ps
`include "list_table_defines.svh"

module update_pipe (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     upt_vld,
  input  list_table_pkg::upt_cmd_t upt_cmd,
  output logic                     upt_error_vld,
  output logic [`LT_ID_W-1:0]      upt_error_id,
  output logic                     ntf_vld,
  output logic [`LT_ID_W-1:0]      ntf_id,
  table_port_if.pipe               upt_port,
  table_port_if.pipe               qry_wr_port
);
  import list_table_pkg::*;

  localparam int SLOT_W = $clog2(`LT_SLOTS);

  // Stage valids, bit n is stage Sn
  logic [3:0]           vld_q;
  upt_cmd_t             cmd_q [4];
  list_state_t          st2_q;
  list_state_t          st3_q;
  list_state_t          st2_sel;

  // Write-back bypass for a read that collides with the S3 write
  logic                 wrbk_hit;
  logic                 wrbk_vld_q;
  list_state_t          wrbk_q;

  // Execute stage
  list_state_t          exe_state;
  logic                 exe_error;
  logic                 exe_ntf;
  logic [`LT_SLOTS-1:0] slot_used;
  logic [`LT_SLOTS-1:0] slot_hit;
  logic [SLOT_W-1:0]    free_idx;
  logic [SLOT_W-1:0]    hit_idx;
  logic [SLOT_W:0]      used_cnt;

  // S0 command meets the S3 write to the same list
  assign wrbk_hit = vld_q[0] && vld_q[3] && (cmd_q[0].id == cmd_q[3].id);

  // Read skipped when the bypass register will supply the state
  assign upt_port.rd_en   = vld_q[0] && !wrbk_hit;
  assign upt_port.rd_addr = cmd_q[0].id;
  assign upt_port.wr_en   = vld_q[3];
  assign upt_port.wr_addr = cmd_q[3].id;
  assign upt_port.wr_data = st3_q;

  // Query copy gets identical writes
  assign qry_wr_port.wr_en   = vld_q[3];
  assign qry_wr_port.wr_addr = cmd_q[3].id;
  assign qry_wr_port.wr_data = st3_q;

  // State for S1 -> S2, newest copy of the list wins
  always_comb begin
    if (vld_q[2] && (cmd_q[2].id == cmd_q[1].id)) begin
      st2_sel = exe_state;
    end else if (vld_q[3] && (cmd_q[3].id == cmd_q[1].id)) begin
      st2_sel = st3_q;
    end else if (wrbk_vld_q) begin
      st2_sel = wrbk_q;
    end else begin
      st2_sel = upt_port.rd_data;
    end
  end

  // Slot flags, lowest free and lowest matching slot, valid count
  always_comb begin
    free_idx = '0;
    hit_idx  = '0;
    used_cnt = '0;
    for (int i = 0; i < `LT_SLOTS; i++) begin
      slot_used[i] = st2_q[i].valid;
      slot_hit[i]  = st2_q[i].valid && (st2_q[i].key == cmd_q[2].key);
      used_cnt     = used_cnt + (SLOT_W + 1)'(slot_used[i]);
    end
    // Scan downwards so the lowest index is kept
    for (int i = `LT_SLOTS - 1; i >= 0; i--) begin
      if (!slot_used[i]) free_idx = SLOT_W'(i);
      if (slot_hit[i]) hit_idx = SLOT_W'(i);
    end
  end

  // Command execution, failed commands keep the list as it was
  always_comb begin
    exe_state = st2_q;
    exe_error = 1'b0;
    case (cmd_q[2].op)
      OP_CLEAR: begin
        exe_state = '0;
      end
      OP_ADD: begin
        exe_error = &slot_used;
        if (!exe_error) begin
          exe_state[free_idx].valid = 1'b1;
          exe_state[free_idx].key   = cmd_q[2].key;
          exe_state[free_idx].size  = cmd_q[2].size;
        end
      end
      OP_DELETE: begin
        exe_error = (slot_hit == '0);
        if (!exe_error) exe_state[hit_idx] = '0;
      end
      OP_REPLACE: begin
        exe_error = (slot_hit == '0);
        if (!exe_error) exe_state[hit_idx].size = cmd_q[2].size;
      end
    endcase
    // List goes empty on CLEAR or on removing its only entry
    exe_ntf = (cmd_q[2].op == OP_CLEAR) ||
              ((cmd_q[2].op == OP_DELETE) && !exe_error && (used_cnt == 1));
  end

  // Control state
  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q         <= '0;
      wrbk_vld_q    <= 1'b0;
      upt_error_vld <= 1'b0;
      ntf_vld       <= 1'b0;
    end else begin
      vld_q         <= {vld_q[2:0], upt_vld};
      wrbk_vld_q    <= wrbk_hit;
      upt_error_vld <= vld_q[2] && exe_error;
      ntf_vld       <= vld_q[2] && exe_ntf;
    end
  end

  // Stage payloads advance only with a valid command
  always_ff @(posedge clk) begin
    if (upt_vld) cmd_q[0] <= upt_cmd;
    if (vld_q[0]) cmd_q[1] <= cmd_q[0];
    if (vld_q[1]) begin
      cmd_q[2] <= cmd_q[1];
      st2_q    <= st2_sel;
    end
    if (vld_q[2]) begin
      cmd_q[3] <= cmd_q[2];
      st3_q    <= exe_state;
    end
    if (wrbk_hit) wrbk_q <= st3_q;
    if (vld_q[2] && exe_error) upt_error_id <= cmd_q[2].id;
    if (vld_q[2] && exe_ntf) ntf_id <= cmd_q[2].id;
  end

endmodule

//--- hdl/query_pipe.sv
// Query pipeline, response three edges after issue; sees only writes landed before its read edge
`timescale 1ns/1ps
`include "list_table_defines.svh"

module query_pipe (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    qry_vld,
  input  logic [`LT_ID_W-1:0]     qry_id,
  input  logic [`LT_LEVEL_W-1:0]  qry_level,
  table_port_if.pipe              qry_port,
  output logic                    qry_resp_vld,
  output logic [`LT_KEY_W-1:0]    qry_key,
  output logic [`LT_SIZE_W-1:0]   qry_size,
  output logic                    qry_error,
  output logic [`LT_LEVEL_W-1:0]  qry_listsize
);
  import list_table_pkg::*;

  typedef logic [`LT_LEVEL_W-1:0] level_t;

  logic [2:0]          vld_q;
  // Id is only needed for the read address
  logic [`LT_ID_W-1:0] id_q;
  level_t              level_q [3];
  list_state_t         st_q;

  entry_t              sel_entry;
  logic                sel_error;
  level_t              sel_count;

  assign qry_port.rd_en   = vld_q[0];
  assign qry_port.rd_addr = id_q;

  // Slot pick by level, count of valid slots
  always_comb begin
    sel_entry = '0;
    sel_count = '0;
    for (int i = 0; i < `LT_SLOTS; i++) begin
      if (level_q[2] == level_t'(i)) sel_entry = st_q[i];
      sel_count = sel_count + level_t'(st_q[i].valid);
    end
    // Out of range level leaves sel_entry cleared as well
    sel_error = (level_q[2] >= level_t'(`LT_SLOTS)) || !sel_entry.valid;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      vld_q        <= '0;
      qry_resp_vld <= 1'b0;
    end else begin
      vld_q        <= {vld_q[1:0], qry_vld};
      qry_resp_vld <= vld_q[2];
    end
  end

  always_ff @(posedge clk) begin
    if (qry_vld) begin
      id_q       <= qry_id;
      level_q[0] <= qry_level;
    end
    if (vld_q[0]) level_q[1] <= level_q[0];
    // Memory word is ready while the query sits in stage 1
    if (vld_q[1]) begin
      level_q[2] <= level_q[1];
      st_q       <= qry_port.rd_data;
    end
    if (vld_q[2]) begin
      qry_key      <= sel_entry.key;
      qry_size     <= sel_entry.size;
      qry_error    <= sel_error;
      qry_listsize <= sel_count;
    end
  end

endmodule

//--- hdl/list_table.sv
// Top of the list table; both ports are valid-only, one item per cycle, never stalled
`timescale 1ns/1ps
`include "list_table_defines.svh"

module list_table (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   upt_vld,
  input  logic [`LT_ID_W-1:0]    upt_id,
  input  logic [1:0]             upt_op,
  input  logic [`LT_KEY_W-1:0]   upt_key,
  input  logic [`LT_SIZE_W-1:0]  upt_size,
  input  logic                   qry_vld,
  input  logic [`LT_ID_W-1:0]    qry_id,
  input  logic [`LT_LEVEL_W-1:0] qry_level,
  output logic                   upt_error_vld,
  output logic [`LT_ID_W-1:0]    upt_error_id,
  output logic                   qry_resp_vld,
  output logic [`LT_KEY_W-1:0]   qry_key,
  output logic [`LT_SIZE_W-1:0]  qry_size,
  output logic                   qry_error,
  output logic [`LT_LEVEL_W-1:0] qry_listsize,
  output logic                   ntf_vld,
  output logic [`LT_ID_W-1:0]    ntf_id
);
  import list_table_pkg::*;

  upt_cmd_t upt_cmd;

  // Update copy, fully owned by the update pipeline
  table_port_if upt_if ();
  // Query copy, write half from updates and read half from queries
  table_port_if qry_if ();

  assign upt_cmd = '{id: upt_id, op: op_e'(upt_op), key: upt_key, size: upt_size};

  update_pipe u_update_pipe (
    .clk           (clk),
    .rst           (rst),
    .upt_vld       (upt_vld),
    .upt_cmd       (upt_cmd),
    .upt_error_vld (upt_error_vld),
    .upt_error_id  (upt_error_id),
    .ntf_vld       (ntf_vld),
    .ntf_id        (ntf_id),
    .upt_port      (upt_if.pipe),
    .qry_wr_port   (qry_if.pipe)
  );

  query_pipe u_query_pipe (
    .clk          (clk),
    .rst          (rst),
    .qry_vld      (qry_vld),
    .qry_id       (qry_id),
    .qry_level    (qry_level),
    .qry_port     (qry_if.pipe),
    .qry_resp_vld (qry_resp_vld),
    .qry_key      (qry_key),
    .qry_size     (qry_size),
    .qry_error    (qry_error),
    .qry_listsize (qry_listsize)
  );

  list_state_ram u_upt_ram (
    .clk  (clk),
    .port (upt_if.mem)
  );

  list_state_ram u_qry_ram (
    .clk  (clk),
    .port (qry_if.mem)
  );

endmodule

//--- tb/list_table_asserts.sv
// Output checks for list_table, bound to every instance; level check assumes the fixed 4-edge query latency
`timescale 1ns/1ps
`include "list_table_defines.svh"

module list_table_asserts (
  input logic                   clk,
  input logic                   rst,
  input logic                   qry_vld,
  input logic [`LT_LEVEL_W-1:0] qry_level,
  input logic                   upt_error_vld,
  input logic                   ntf_vld,
  input logic                   qry_resp_vld,
  input logic                   qry_error,
  input logic [`LT_LEVEL_W-1:0] qry_listsize
);

  // Running count of failed assertions
  int fail_cnt = 0;

  // Outputs stay quiet once reset has been seen for a full cycle
  a_quiet_in_reset: assert property (@(posedge clk)
    (rst && $past(rst)) |-> (!upt_error_vld && !ntf_vld && !qry_resp_vld))
    else begin
      fail_cnt++;
      $error("valid output high during reset");
    end

  // A failed command never empties a list
  a_ntf_err_excl: assert property (@(posedge clk) disable iff (rst)
    !(ntf_vld && upt_error_vld))
    else begin
      fail_cnt++;
      $error("ntf_vld and upt_error_vld high together");
    end

  a_listsize_range: assert property (@(posedge clk) disable iff (rst)
    qry_resp_vld |-> (qry_listsize <= `LT_SLOTS))
    else begin
      fail_cnt++;
      $error("qry_listsize above slot count");
    end

  // Response shows up four edges after the query is sampled
  a_level_range: assert property (@(posedge clk) disable iff (rst)
    (qry_vld && (qry_level >= `LT_SLOTS)) |-> ##4 (qry_resp_vld && qry_error))
    else begin
      fail_cnt++;
      $error("out of range level without qry_error");
    end

endmodule

bind list_table list_table_asserts u_list_table_asserts (.*);

//--- tb/tb_list_table.sv
// Testbench for list_table; queries are issued only after updates have drained, ids 40-43 are random
`timescale 1ns/1ps
`include "list_table_defines.svh"

module tb_list_table;
  import list_table_pkg::*;

  localparam int RAND_CMDS  = 400;
  localparam int ROUNDS     = 8;
  localparam int RAND_IDS   = 4;
  localparam int QRY_LEVELS = 6;
  // Directed updates plus directed queries
  localparam int DIR_ITEMS  = 47;
  localparam int CYCLE_LIMIT =
    (DIR_ITEMS + RAND_CMDS + ROUNDS * RAND_IDS * QRY_LEVELS) * 2 + 200;

  typedef struct {
    logic                   error;
    logic [`LT_LEVEL_W-1:0] listsize;
    logic [`LT_KEY_W-1:0]   key;
    logic [`LT_SIZE_W-1:0]  size;
    logic [`LT_ID_W-1:0]    id;
    logic [`LT_LEVEL_W-1:0] level;
  } qry_exp_t;

  logic                   clk;
  logic                   rst;
  logic                   upt_vld;
  logic [`LT_ID_W-1:0]    upt_id;
  logic [1:0]             upt_op;
  logic [`LT_KEY_W-1:0]   upt_key;
  logic [`LT_SIZE_W-1:0]  upt_size;
  logic                   qry_vld;
  logic [`LT_ID_W-1:0]    qry_id;
  logic [`LT_LEVEL_W-1:0] qry_level;
  logic                   upt_error_vld;
  logic [`LT_ID_W-1:0]    upt_error_id;
  logic                   qry_resp_vld;
  logic [`LT_KEY_W-1:0]   qry_key;
  logic [`LT_SIZE_W-1:0]  qry_size;
  logic                   qry_error;
  logic [`LT_LEVEL_W-1:0] qry_listsize;
  logic                   ntf_vld;
  logic [`LT_ID_W-1:0]    ntf_id;

  // Reference table and expected responses in issue order
  list_state_t            model [`LT_LISTS];
  logic [`LT_ID_W-1:0]    err_q [$];
  logic [`LT_ID_W-1:0]    ntf_q [$];
  qry_exp_t               qry_q [$];
  int n_upt_err;
  int n_ntf_err;
  int n_qry_err;
  int n_other;
  int cycles;

  list_table i_list_table (.*);

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // Applies one command to the model, lowest free or lowest matching slot wins
  function automatic void ref_update(input logic [`LT_ID_W-1:0] id, input op_e op,
                                     input logic [`LT_KEY_W-1:0] key,
                                     input logic [`LT_SIZE_W-1:0] size,
                                     output logic err, output logic ntf);
    list_state_t st;
    int free_i;
    int hit_i;
    int used;
    st = model[id];
    free_i = -1;
    hit_i = -1;
    used = 0;
    for (int i = 0; i < `LT_SLOTS; i++) begin
      if (st[i].valid) used++;
      if (!st[i].valid && free_i < 0) free_i = i;
      if (st[i].valid && st[i].key == key && hit_i < 0) hit_i = i;
    end
    err = 1'b0;
    ntf = 1'b0;
    case (op)
      OP_CLEAR: begin
        st = '0;
        ntf = 1'b1;
      end
      OP_ADD: begin
        if (free_i < 0) begin
          err = 1'b1;
        end else begin
          st[free_i].valid = 1'b1;
          st[free_i].key = key;
          st[free_i].size = size;
        end
      end
      OP_DELETE: begin
        if (hit_i < 0) begin
          err = 1'b1;
        end else begin
          st[hit_i] = '0;
          // Only entry gone means the list is now empty
          ntf = (used == 1);
        end
      end
      default: begin
        if (hit_i < 0) err = 1'b1;
        else st[hit_i].size = size;
      end
    endcase
    model[id] = st;
  endfunction

  // Expected query response from the current model
  function automatic qry_exp_t ref_query(input logic [`LT_ID_W-1:0] id,
                                         input logic [`LT_LEVEL_W-1:0] level);
    qry_exp_t r;
    r.id = id;
    r.level = level;
    r.key = '0;
    r.size = '0;
    r.listsize = '0;
    for (int i = 0; i < `LT_SLOTS; i++) begin
      if (model[id][i].valid) r.listsize++;
    end
    if (level < `LT_SLOTS) begin
      r.error = !model[id][level].valid;
      r.key = model[id][level].key;
      r.size = model[id][level].size;
    end else begin
      r.error = 1'b1;
    end
    return r;
  endfunction

  task automatic drive_update(input logic [`LT_ID_W-1:0] id, input op_e op,
                              input logic [`LT_KEY_W-1:0] key,
                              input logic [`LT_SIZE_W-1:0] size);
    logic err;
    logic ntf;
    @(posedge clk);
    #1;
    upt_vld = 1'b1;
    upt_id = id;
    upt_op = op;
    upt_key = key;
    upt_size = size;
    qry_vld = 1'b0;
    ref_update(id, op, key, size, err, ntf);
    if (err) err_q.push_back(id);
    if (ntf) ntf_q.push_back(id);
  endtask

  task automatic drive_query(input logic [`LT_ID_W-1:0] id,
                             input logic [`LT_LEVEL_W-1:0] level);
    @(posedge clk);
    #1;
    upt_vld = 1'b0;
    qry_vld = 1'b1;
    qry_id = id;
    qry_level = level;
    qry_q.push_back(ref_query(id, level));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      upt_vld = 1'b0;
      qry_vld = 1'b0;
    end
  endtask

  // Compare at the falling edge, away from the registered output updates
  always @(negedge clk) begin : compare
    logic [`LT_ID_W-1:0] exp_id;
    qry_exp_t e;
    if (!rst && upt_error_vld) begin
      if (err_q.size() == 0) begin
        $display("Unexpected upt_error_vld for list %0d at %0t, no failing command pending",
                 upt_error_id, $time);
        n_other++;
      end else begin
        exp_id = err_q.pop_front();
        if (upt_error_id !== exp_id) begin
          $display("error at %0t: upt_error_id %0d, expected %0d", $time, upt_error_id, exp_id);
          n_upt_err++;
        end
      end
    end
    if (!rst && ntf_vld) begin
      if (ntf_q.size() == 0) begin
        $display("Unexpected ntf_vld for list %0d at %0t, no list was emptied", ntf_id, $time);
        n_other++;
      end else begin
        exp_id = ntf_q.pop_front();
        if (ntf_id !== exp_id) begin
          $display("error at %0t: ntf_id %0d, expected %0d", $time, ntf_id, exp_id);
          n_ntf_err++;
        end
      end
    end
    if (!rst && qry_resp_vld) begin
      if (qry_q.size() == 0) begin
        $display("Unexpected qry_resp_vld at %0t, no query pending", $time);
        n_other++;
      end else begin
        e = qry_q.pop_front();
        if (qry_error !== e.error || qry_listsize !== e.listsize) begin
          $display("error at %0t: list %0d level %0d error/size %b/%0d, expected %b/%0d",
                   $time, e.id, e.level, qry_error, qry_listsize, e.error, e.listsize);
          n_qry_err++;
        end
        // Entry fields only count for an occupied slot
        if (!e.error && (qry_key !== e.key || qry_size !== e.size)) begin
          $display("error at %0t: list %0d level %0d entry %h/%h, expected %h/%h",
                   $time, e.id, e.level, qry_key, qry_size, e.key, e.size);
          n_qry_err++;
        end
      end
    end
  end

  initial begin : watchdog
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run stopped at the %0d cycle limit before the tests finished", cycles);
    $display(">>> FAIL");
    $finish;
  end

  initial begin : stimulus
    int r;
    logic [`LT_ID_W-1:0] id;
    op_e op;
    rst = 1'b1;
    upt_vld = 1'b0;
    upt_id = '0;
    upt_op = '0;
    upt_key = '0;
    upt_size = '0;
    qry_vld = 1'b0;
    qry_id = '0;
    qry_level = '0;
    n_upt_err = 0;
    n_ntf_err = 0;
    n_qry_err = 0;
    n_other = 0;
    void'($urandom(32'h19b3));
    for (int i = 0; i < `LT_LISTS; i++) model[i] = '0;
    repeat (8) @(posedge clk);
    #1 rst = 1'b0;

    // Fill list 5, the fifth ADD overflows
    for (int i = 0; i < 5; i++) drive_update(6'd5, OP_ADD, 64'hA5A5_0000_0000_0010 + i, 100 + i);
    idle_cycles(8);
    for (int lv = 0; lv < 5; lv++) drive_query(6'd5, lv);

    // Duplicate key, delete lowest match, absent key failures, size replace
    drive_update(6'd9, OP_ADD, 64'h0000_0000_0000_00AA, 32'd1);
    drive_update(6'd9, OP_ADD, 64'h0000_0000_0000_00BB, 32'd2);
    drive_update(6'd9, OP_ADD, 64'h0000_0000_0000_00AA, 32'd3);
    drive_update(6'd9, OP_DELETE, 64'h0000_0000_0000_00AA, 32'd0);
    drive_update(6'd9, OP_DELETE, 64'h0000_0000_0000_00CC, 32'd0);
    drive_update(6'd9, OP_REPLACE, 64'h0000_0000_0000_00CC, 32'd9);
    drive_update(6'd9, OP_REPLACE, 64'h0000_0000_0000_00BB, 32'd77);
    idle_cycles(8);
    for (int lv = 0; lv < 4; lv++) drive_query(6'd9, lv);

    // Notification on CLEAR and on removing the last entry
    drive_update(6'd5, OP_CLEAR, 64'h0, 32'd0);
    drive_update(6'd12, OP_ADD, 64'h1234, 32'd5);
    drive_update(6'd12, OP_ADD, 64'h5678, 32'd6);
    drive_update(6'd12, OP_DELETE, 64'h1234, 32'd0);
    drive_update(6'd12, OP_DELETE, 64'h5678, 32'd0);
    idle_cycles(8);
    drive_query(6'd5, 8'd0);
    drive_query(6'd12, 8'd1);
    drive_query(6'd12, 8'd9);
    drive_query(6'd5, 8'd255);

    // Same id every cycle with other lists in between covers S2, S3 and write-back forwarding
    drive_update(6'd20, OP_ADD, 64'h11, 32'd1);
    drive_update(6'd20, OP_ADD, 64'h22, 32'd2);
    drive_update(6'd21, OP_ADD, 64'h44, 32'd4);
    drive_update(6'd22, OP_ADD, 64'h55, 32'd5);
    drive_update(6'd20, OP_DELETE, 64'h11, 32'd0);
    drive_update(6'd21, OP_ADD, 64'h66, 32'd6);
    drive_update(6'd20, OP_REPLACE, 64'h22, 32'd20);
    drive_update(6'd20, OP_ADD, 64'h33, 32'd3);
    drive_update(6'd20, OP_REPLACE, 64'h33, 32'd30);
    drive_update(6'd20, OP_DELETE, 64'h22, 32'd0);
    drive_update(6'd20, OP_DELETE, 64'h33, 32'd0);
    idle_cycles(8);
    for (int lv = 0; lv < 4; lv++) drive_query(6'd20, lv);
    for (int lv = 0; lv < 2; lv++) drive_query(6'd21, lv);

    // Random rounds, small key pool so deletes and replaces hit often
    for (int rnd = 0; rnd < ROUNDS; rnd++) begin
      for (int c = 0; c < RAND_CMDS / ROUNDS; c++) begin
        id = 6'd40 + ($urandom % RAND_IDS);
        r = $urandom % 16;
        if (r == 0) op = OP_CLEAR;
        else if (r < 8) op = OP_ADD;
        else if (r < 12) op = OP_DELETE;
        else op = OP_REPLACE;
        drive_update(id, op, 64'hC0DE_0000_0000_0000 | ($urandom % 6), $urandom);
      end
      idle_cycles(8);
      for (int k = 0; k < RAND_IDS; k++) begin
        for (int lv = 0; lv < QRY_LEVELS; lv++) drive_query(6'd40 + k, lv);
      end
    end

    idle_cycles(12);
    if (err_q.size() != 0) begin
      $display("%0d expected upt_error_vld responses never arrived", err_q.size());
      n_other++;
    end
    if (ntf_q.size() != 0) begin
      $display("%0d expected ntf_vld responses never arrived", ntf_q.size());
      n_other++;
    end
    if (qry_q.size() != 0) begin
      $display("%0d expected query responses never arrived", qry_q.size());
      n_other++;
    end
    if (i_list_table.u_list_table_asserts.fail_cnt != 0) begin
      $display("%0d bound assertion failures were seen",
               i_list_table.u_list_table_asserts.fail_cnt);
      n_other++;
    end
    $display("Error counts: update %0d, notify %0d, query %0d, other %0d",
             n_upt_err, n_ntf_err, n_qry_err, n_other);
    if (n_upt_err + n_ntf_err + n_qry_err + n_other == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

//--- tb.f
+incdir+include
hdl/list_table_pkg.sv
hdl/table_port_if.sv
hdl/list_state_ram.sv
hdl/update_pipe.sv
hdl/query_pipe.sv
hdl/list_table.sv
tb/list_table_asserts.sv
tb/tb_list_table.sv

//--- Bender.yml
package:
  name: list_table

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/list_table_pkg.sv
      - hdl/table_port_if.sv
      - hdl/list_state_ram.sv
      - hdl/update_pipe.sv
      - hdl/query_pipe.sv
      - hdl/list_table.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/list_table_asserts.sv
      - tb/tb_list_table.sv
